//--- common/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// address and data widths
`define CACHE_ADDR_W      16 // byte address from the pipeline
`define CACHE_WORD_W      16 // one data word

// address split, tag | set | word | byte
`define CACHE_TAG_W       5  // addr[15:11]
`define CACHE_SET_W       7  // addr[10:4]
`define CACHE_SETS        128 // direct mapped, one block per set

// block geometry
`define CACHE_WORD_SEL_W  3  // addr[3:1] picks the word
`define CACHE_BLOCK_WORDS 8  // words fetched per fill

`endif

//--- common/cache_pkg.sv
package cache_pkg;

	`include "cache_consts.svh"

	typedef logic [`CACHE_ADDR_W-1:0]     addr_t; // byte address
	typedef logic [`CACHE_WORD_W-1:0]     word_t; // data word
	typedef logic [`CACHE_TAG_W-1:0]      tag_t; // upper address bits kept per set
	typedef logic [`CACHE_SET_W-1:0]      set_idx_t; // row of the tag and data stores
	typedef logic [`CACHE_WORD_SEL_W-1:0] word_sel_t; // word inside a block

	// overlays addr_t, msb first
	typedef struct packed {
		tag_t      tag; // [15:11]
		set_idx_t  set; // [10:4]
		word_sel_t word; // [3:1]
		logic      byte_off; // [0], ignored since memory is word wide
	} cache_addr_t;

	// one row of the tag store
	typedef struct packed {
		logic valid; // block holds real data
		tag_t tag; // tag of the block held
	} tag_entry_t;

	// miss fill sequencing
	typedef enum logic [1:0] {
		FILL_IDLE, // no fill, cache serves hits
		FILL_ISSUE, // sending the eight block reads
		FILL_DRAIN // all reads sent, waiting on returns
	} fill_state_t;

endpackage

//--- cache/cache_tag_store.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_tag_store (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  write, // fill done, install tag
	input  cache_pkg::set_idx_t   set, // row addressed by the request
	input  cache_pkg::tag_t       write_tag, // tag of the block just filled
	output cache_pkg::tag_entry_t entry // valid and tag at set, no clock
);
	import cache_pkg::*;

	logic [`CACHE_SETS-1:0] valid; // one valid bit per set
	tag_t                   tags [`CACHE_SETS]; // tag memory

	// valid bits are control state, cleared on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0; // every block invalid after reset
		end else if (write) begin
			valid[set] <= 1'b1; // block now present
		end
	end

	// tag memory itself carries no reset
	always_ff @(posedge clk) begin
		if (write) begin
			tags[set] <= write_tag; // same cycle as the valid bit
		end
	end

	// asynchronous read so the hit is known in the request cycle
	always_comb begin
		entry.valid = valid[set];
		entry.tag   = tags[set];
	end

	// an X set index would mark an unknown row valid
	assert property (@(posedge clk) disable iff (reset)
		write |-> !$isunknown(set))
		else $error("tag store write with unknown set index");

endmodule

//--- cache/cache_data_store.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_data_store (
	input  logic                 clk,
	input  logic                 write, // one word per cycle, fill or write hit
	input  cache_pkg::set_idx_t  set, // block row
	input  cache_pkg::word_sel_t word_sel, // word inside the block
	input  cache_pkg::word_t     write_data, // fill return or pipeline data
	output cache_pkg::word_t     read_data // word at set and word_sel
);
	import cache_pkg::*;

	// 128 blocks by 8 words, no reset on payload
	word_t mem [`CACHE_SETS][`CACHE_BLOCK_WORDS];

	// single word write port
	// the row comes from the held request, the word from
	// the fill controller during a fill or from the address on a hit
	always_ff @(posedge clk) begin
		if (write) begin
			mem[set][word_sel] <= write_data; // visible on the read port next cycle
		end
	end

	// asynchronous read, a read hit returns in the request cycle
	assign read_data = mem[set][word_sel];

endmodule

//--- cache/cache_fill_ctrl.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_fill_ctrl (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 miss, // miss level, only high while idle
	input  cache_pkg::addr_t     miss_addr, // request address that missed
	input  logic                 mem_valid, // one returned word
	output logic                 busy, // fill in progress
	output logic                 mem_read, // one word read per cycle
	output cache_pkg::addr_t     mem_read_addr, // block word address being read
	output logic                 fill_word_write, // store the returned word
	output cache_pkg::word_sel_t fill_word_sel, // where the returned word goes
	output logic                 tag_write // last word back, block valid
);
	import cache_pkg::*;

	localparam int CNT_W = `CACHE_WORD_SEL_W + 1; // counts 0 to 8
	localparam logic [CNT_W-1:0] LAST = CNT_W'(`CACHE_BLOCK_WORDS - 1);

	fill_state_t      state;
	fill_state_t      state_next;
	cache_addr_t      block; // latched miss address
	cache_addr_t      rd_addr; // block with the issue word filled in
	logic [CNT_W-1:0] issue_cnt; // reads sent so far
	logic [CNT_W-1:0] recv_cnt; // words returned so far
	logic             last_issue; // eighth read goes out this cycle
	logic             last_recv; // eighth word comes back this cycle

	assign last_issue = (issue_cnt == LAST);
	assign last_recv  = mem_valid && (recv_cnt == LAST);

	always_comb begin
		state_next = state;
		case (state)
			FILL_IDLE: begin
				if (miss) state_next = FILL_ISSUE; // first read next cycle
			end
			FILL_ISSUE: begin
				if (last_issue) state_next = FILL_DRAIN; // all eight sent
			end
			FILL_DRAIN: begin
				state_next = FILL_DRAIN; // waits on outstanding returns
			end
			default: begin
				state_next = FILL_IDLE;
			end
		endcase
		// the return count alone ends the fill
		if (state != FILL_IDLE && last_recv) state_next = FILL_IDLE;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= FILL_IDLE;
			issue_cnt <= '0;
			recv_cnt  <= '0;
		end else begin
			state <= state_next;
			if (state == FILL_IDLE) begin
				issue_cnt <= '0; // ready for the next miss
				recv_cnt  <= '0;
			end else begin
				if (mem_read) issue_cnt <= issue_cnt + 1'b1; // issue side
				if (mem_valid) recv_cnt <= recv_cnt + 1'b1; // return side, independent
			end
		end
	end

	// miss address held for the whole fill
	always_ff @(posedge clk) begin
		if (state == FILL_IDLE && miss) begin
			block <= miss_addr;
		end
	end

	// word addresses 0 to 7 of the block, in order
	always_comb begin
		rd_addr          = block;
		rd_addr.word     = issue_cnt[`CACHE_WORD_SEL_W-1:0];
		rd_addr.byte_off = 1'b0;
	end

	assign mem_read_addr   = rd_addr;
	assign busy            = (state != FILL_IDLE);
	assign mem_read        = (state == FILL_ISSUE);
	assign fill_word_write = busy && mem_valid; // returns land in order
	assign fill_word_sel   = recv_cnt[`CACHE_WORD_SEL_W-1:0];
	assign tag_write       = busy && last_recv; // with the eighth word

	// returns only ever answer reads of a fill
	assert property (@(posedge clk) disable iff (reset)
		(state == FILL_IDLE) |-> !mem_valid)
		else $error("fill: mem_valid with no fill in progress");

	// issue phase ends after the eighth read
	assert property (@(posedge clk) disable iff (reset)
		mem_read |-> (issue_cnt < CNT_W'(`CACHE_BLOCK_WORDS)))
		else $error("fill: more block reads than words in a block");

	// memory returns in order and never early
	assert property (@(posedge clk) disable iff (reset)
		recv_cnt <= issue_cnt)
		else $error("fill: more words returned than requested");

endmodule

//--- verilog/cache_top.sv
`timescale 1ns/1ps

module cache_top (
	input  logic             clk,
	input  logic             reset,
	// pipeline side
	input  logic             pipe_read, // read request level
	input  logic             pipe_write, // write request level, wins the mux
	input  cache_pkg::addr_t pipe_read_addr,
	input  cache_pkg::addr_t pipe_write_addr,
	input  cache_pkg::word_t pipe_write_data,
	// memory returns
	input  logic             mem_valid, // one pulse per read, in issue order
	input  cache_pkg::word_t mem_read_data,
	// memory requests
	output logic             mem_read, // fill read strobe
	output logic             mem_write, // write-through strobe
	output cache_pkg::addr_t mem_addr, // shared by reads and writes
	output cache_pkg::word_t mem_write_data,
	// back to the pipeline
	output cache_pkg::word_t cache_data_out, // read hit word, same cycle
	output logic             stall // pipeline holds its request while high
);
	import cache_pkg::*;

	addr_t       req_addr; // write address if writing, else read address
	cache_addr_t req; // split view of req_addr
	logic        req_present; // either request level high
	tag_entry_t  entry; // tag store row at req.set
	logic        hit;
	logic        miss;
	logic        write_hit; // write through this cycle
	logic        fill_busy;
	logic        fill_word_write;
	word_sel_t   fill_word_sel;
	addr_t       fill_read_addr;
	logic        tag_write;
	logic        data_write; // data store write strobe
	word_sel_t   data_word_sel;
	word_t       data_write_data;

	assign req_addr    = pipe_write ? pipe_write_addr : pipe_read_addr;
	assign req         = req_addr;
	assign req_present = pipe_read | pipe_write;

	assign hit       = entry.valid && (entry.tag == req.tag);
	assign miss      = req_present && !hit && !fill_busy; // starts a fill
	assign write_hit = pipe_write && hit && !fill_busy;
	assign stall     = miss | fill_busy; // rises in the request cycle

	cache_tag_store tags0 (
		.clk       (clk),
		.reset     (reset),
		.write     (tag_write),
		.set       (req.set),
		.write_tag (req.tag), // request is held through the fill
		.entry     (entry)
	);

	// fill owns the data port while busy, else the write hit
	assign data_write      = fill_word_write | write_hit;
	assign data_word_sel   = fill_busy ? fill_word_sel : req.word;
	assign data_write_data = fill_busy ? mem_read_data : pipe_write_data;

	cache_data_store data0 (
		.clk        (clk),
		.write      (data_write),
		.set        (req.set),
		.word_sel   (data_word_sel),
		.write_data (data_write_data),
		.read_data  (cache_data_out)
	);

	cache_fill_ctrl fill0 (
		.clk             (clk),
		.reset           (reset),
		.miss            (miss),
		.miss_addr       (req_addr),
		.mem_valid       (mem_valid),
		.busy            (fill_busy),
		.mem_read        (mem_read),
		.mem_read_addr   (fill_read_addr),
		.fill_word_write (fill_word_write),
		.fill_word_sel   (fill_word_sel),
		.tag_write       (tag_write)
	);

	// write through, same address and data as the cache update
	assign mem_write      = write_hit;
	assign mem_addr       = fill_busy ? fill_read_addr : pipe_write_addr;
	assign mem_write_data = pipe_write_data;

	// fill reads and the write through share mem_addr
	assert property (@(posedge clk) disable iff (reset)
		!(mem_write && mem_read))
		else $error("cache: memory write during a fill read");

endmodule

//--- sim/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
	parameter int latency = 3 // cycles from read strobe to mem_valid, at least one
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             mem_read, // one word read per high cycle
	input  logic             mem_write, // one word write per high cycle
	input  cache_pkg::addr_t mem_addr, // byte address, bit 0 ignored
	input  cache_pkg::word_t mem_write_data,
	output logic             mem_valid, // one pulse per read, in issue order
	output cache_pkg::word_t mem_read_data
);
	import cache_pkg::*;

	word_t              words [32768]; // one entry per word address
	logic [14:0]        rd_addr_q [latency]; // word address of each read in flight
	logic [latency-1:0] rd_valid_q; // read in flight per stage

	// every word starts from its own word address
	initial begin
		for (int i = 0; i < 32768; i++) begin
			words[i] = word_t'(i * 3) ^ 16'ha5a5;
		end
	end

	always @(posedge clk) begin
		if (mem_write) begin
			words[mem_addr[15:1]] <= mem_write_data; // write lands at the clock edge
		end
	end

	// read pipeline, several reads can be in flight
	always @(posedge clk) begin
		if (reset) begin
			rd_valid_q <= '0;
		end else begin
			rd_valid_q[0] <= mem_read;
			for (int i = 1; i < latency; i++) begin
				rd_valid_q[i] <= rd_valid_q[i-1];
			end
		end
	end

	always @(posedge clk) begin
		rd_addr_q[0] <= mem_addr[15:1]; // payload only
		for (int i = 1; i < latency; i++) begin
			rd_addr_q[i] <= rd_addr_q[i-1];
		end
	end

	assign mem_valid     = rd_valid_q[latency-1];
	assign mem_read_data = words[rd_addr_q[latency-1]]; // read at return time

endmodule

//--- sim/cache_tb.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_tb;
	import cache_pkg::*;

	localparam int num_ops = 70; // requests plus the reset phase
	localparam int cycles_per_op = 40; // worst case per request, with margin
	localparam int period = 20; // ns

	logic   clk = 1'b0;
	logic   reset;
	logic   pipe_read;
	logic   pipe_write;
	addr_t  pipe_read_addr;
	addr_t  pipe_write_addr;
	word_t  pipe_write_data;
	logic   mem_read;
	logic   mem_write;
	logic   mem_valid;
	addr_t  mem_addr;
	word_t  mem_write_data;
	word_t  mem_read_data;
	word_t  cache_data_out;
	logic   stall;

	string  test_name = "reset";
	logic   idle_check = 1'b0; // outputs must be quiet
	logic   req_start = 1'b0; // first cycle of a request
	logic   check_cycle = 1'b0; // last cycle of a request, stall low
	logic   is_write = 1'b0;
	logic   exp_miss = 1'b0; // model says the block is absent
	int     exp_reads = 0; // mem_read pulses expected for this request
	addr_t  exp_addr = '0;
	word_t  exp_data = '0;
	int     rd_count = 0; // every mem_read seen since time zero
	int     rd_base = 0; // rd_count at request start
	int     reads_in_op;
	addr_t  exp_fill_addr; // address the next fill read must carry

	word_t  shadow [32768]; // expected memory contents
	logic   model_valid [`CACHE_SETS]; // which block each set holds
	tag_t   model_tag [`CACHE_SETS];
	integer seed = 94;
	int     stall_errors = 0;
	int     read_errors = 0;
	int     mem_errors = 0;

	always #(period / 2) clk = ~clk;

	cache_top dut0 (
		.clk             (clk),
		.reset           (reset),
		.pipe_read       (pipe_read),
		.pipe_write      (pipe_write),
		.pipe_read_addr  (pipe_read_addr),
		.pipe_write_addr (pipe_write_addr),
		.pipe_write_data (pipe_write_data),
		.mem_valid       (mem_valid),
		.mem_read_data   (mem_read_data),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.mem_addr        (mem_addr),
		.mem_write_data  (mem_write_data),
		.cache_data_out  (cache_data_out),
		.stall           (stall)
	);

	mem_model #(.latency(3)) mem0 (
		.clk            (clk),
		.reset          (reset),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.mem_addr       (mem_addr),
		.mem_write_data (mem_write_data),
		.mem_valid      (mem_valid),
		.mem_read_data  (mem_read_data)
	);

	// mem_read is stable mid cycle, count it there
	always @(negedge clk) begin
		if (mem_read) rd_count <= rd_count + 1;
	end

	assign reads_in_op   = rd_count - rd_base; // includes a read in the current cycle
	assign exp_fill_addr = {exp_addr[15:4], 3'(reads_in_op - 1), 1'b0}; // word 0 to 7 in turn

	assert property (@(posedge clk) disable iff (reset)
		idle_check |-> !stall && !mem_read && !mem_write)
		else begin
			stall_errors++;
			$display("[ERROR] %s: stall,mem_read,mem_write expected 000 actual %b%b%b",
				test_name, $sampled(stall), $sampled(mem_read), $sampled(mem_write));
		end

	assert property (@(posedge clk) disable iff (reset)
		req_start |-> stall == exp_miss) // miss shows in the request cycle
		else begin
			stall_errors++;
			$display("[ERROR] %s: stall expected %b actual %b", test_name, exp_miss, $sampled(stall));
		end

	assert property (@(posedge clk) disable iff (reset)
		mem_read |-> reads_in_op >= 1 && reads_in_op <= `CACHE_BLOCK_WORDS
			&& mem_addr == exp_fill_addr)
		else begin
			mem_errors++;
			$display("[ERROR] %s: fill read address expected %h actual %h (read %0d)",
				test_name, $sampled(exp_fill_addr), $sampled(mem_addr), $sampled(reads_in_op));
		end

	assert property (@(posedge clk) disable iff (reset)
		check_cycle |-> reads_in_op == exp_reads) // eight on a miss, none on a hit
		else begin
			mem_errors++;
			$display("[ERROR] %s: mem_read count expected %0d actual %0d",
				test_name, exp_reads, $sampled(reads_in_op));
		end

	assert property (@(posedge clk) disable iff (reset)
		check_cycle && !is_write |-> cache_data_out == exp_data)
		else begin
			read_errors++;
			$display("[ERROR] %s: read data expected %h actual %h",
				test_name, exp_data, $sampled(cache_data_out));
		end

	assert property (@(posedge clk) disable iff (reset)
		check_cycle && is_write |-> mem_write && mem_addr == exp_addr && mem_write_data == exp_data)
		else begin
			mem_errors++;
			$display("[ERROR] %s: write addr/data expected %h/%h actual %h/%h mem_write %b",
				test_name, exp_addr, exp_data, $sampled(mem_addr), $sampled(mem_write_data),
				$sampled(mem_write));
		end

	assert property (@(posedge clk) disable iff (reset)
		mem_write |-> check_cycle && is_write) // one pulse per write only
		else begin
			mem_errors++;
			$display("[ERROR] %s: mem_write expected 0 actual 1", test_name);
		end

	// one request, held until stall is low, then released
	task automatic access(input logic write, input addr_t addr, input word_t data);
		cache_addr_t a;
		a = addr;
		@(negedge clk);
		exp_miss = !(model_valid[a.set] && model_tag[a.set] == a.tag);
		exp_reads = exp_miss ? `CACHE_BLOCK_WORDS : 0;
		exp_addr = addr;
		exp_data = write ? data : shadow[addr[15:1]];
		is_write = write;
		rd_base = rd_count; // no fill read at this edge
		pipe_write = write;
		pipe_read = !write;
		pipe_read_addr = addr;
		pipe_write_addr = addr;
		pipe_write_data = data;
		req_start = 1'b1;
		#1; // stall settles after the new request
		while (stall) begin
			@(negedge clk);
			req_start = 1'b0;
			#1;
		end
		check_cycle = 1'b1; // hit cycle, checked at the next rising edge
		@(negedge clk);
		req_start = 1'b0;
		check_cycle = 1'b0;
		pipe_read = 1'b0;
		pipe_write = 1'b0;
		model_valid[a.set] = 1'b1;
		model_tag[a.set] = a.tag;
		if (write) shadow[addr[15:1]] = data;
	endtask

	initial begin
		integer r;
		addr_t  rand_addr;
		word_t  rand_data;
		pipe_read = 1'b0;
		pipe_write = 1'b0;
		pipe_read_addr = '0;
		pipe_write_addr = '0;
		pipe_write_data = '0;
		reset = 1'b1;
		for (int i = 0; i < 32768; i++) shadow[i] = word_t'(i * 3) ^ 16'ha5a5;
		for (int i = 0; i < `CACHE_SETS; i++) model_valid[i] = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		idle_check = 1'b1; // nothing requested yet
		repeat (2) @(negedge clk);
		idle_check = 1'b0;

		test_name = "read_miss";
		access(1'b0, 16'h1234, 16'h0000);
		test_name = "read_hit";
		access(1'b0, 16'h123a, 16'h0000); // other word, same block
		test_name = "write_hit";
		access(1'b1, 16'h1236, 16'hbeef);
		access(1'b0, 16'h1236, 16'h0000);
		test_name = "write_miss";
		access(1'b1, 16'h4568, 16'h5a5a);
		access(1'b0, 16'h4568, 16'h0000);
		test_name = "conflict";
		access(1'b0, 16'h2150, 16'h0000); // set 15h tag 04h
		access(1'b0, 16'h7152, 16'h0000); // same set tag 0eh
		access(1'b0, 16'h2154, 16'h0000); // evicted, misses again

		test_name = "random_mix";
		for (int n = 0; n < 60; n++) begin
			r = $random(seed);
			rand_addr = {3'b000, r[1:0], 4'b0000, r[4:2], r[7:5], 1'b0}; // 4 tags by 8 sets
			rand_data = word_t'($random(seed));
			access(r[8], rand_addr, rand_data);
		end

		@(negedge clk);
		$display("error counts: stall %0d, read data %0d, memory %0d",
			stall_errors, read_errors, mem_errors);
		if (stall_errors + read_errors + mem_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// stops a run that hangs on a stall that never falls
	initial begin
		#(num_ops * cycles_per_op * period);
		$display("watchdog: run did not end within %0d cycles", num_ops * cycles_per_op);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- src.f
+incdir+common
common/cache_pkg.sv
cache/cache_tag_store.sv
cache/cache_data_store.sv
cache/cache_fill_ctrl.sv
verilog/cache_top.sv
sim/mem_model.sv
sim/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_tb -f src.f -o cache_tb_sim \
	> build.log 2>&1 \
	&& ./obj_dir/cache_tb_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
exit 0
